/* src/fetch_pkg.sv */
//********************************************************************
// Fetch front end package
// Word and opcode types, the JAL opcode, APB requester states
//********************************************************************

package fetch_pkg;

  // Instruction or address word
  typedef logic [31:0] word_t;

  // Major opcode field, instr[6:0]
  typedef logic [6:0] opcode_t;

  // RV32I JAL, the only control transfer resolved here
  localparam opcode_t OPC_JAL = 7'b1101111;

  // APB requester phases
  typedef enum logic [1:0] {
    APB_IDLE   = 2'd0,
    APB_SETUP  = 2'd1,
    APB_ACCESS = 2'd2
  } apb_state_t;

endpackage

/* src/imem_apb_master.sv */
//********************************************************************
// Instruction memory APB requester
// One read request becomes a setup/access transfer; the word is
// returned with a single-cycle completion pulse
//********************************************************************

module imem_apb_master (
  input  logic            CLK,
  input  logic            nRST,
  // Request side, from fetch
  input  logic            req_valid,
  input  fetch_pkg::word_t req_addr,
  output logic            req_ready,
  output logic            rsp_valid,
  output fetch_pkg::word_t rsp_data,
  // APB side
  output fetch_pkg::word_t paddr,
  output logic            psel,
  output logic            penable,
  output logic            pwrite,
  input  fetch_pkg::word_t prdata,
  input  logic            pready
);

  fetch_pkg::apb_state_t state_q, state_d;
  fetch_pkg::word_t      addr_q;

  // Phase sequencing
  always_comb begin
    state_d = state_q;
    case (state_q)
      fetch_pkg::APB_IDLE:   if (req_valid) state_d = fetch_pkg::APB_SETUP;
      fetch_pkg::APB_SETUP:  state_d = fetch_pkg::APB_ACCESS;
      fetch_pkg::APB_ACCESS: if (pready) state_d = fetch_pkg::APB_IDLE;
      default:               state_d = fetch_pkg::APB_IDLE;
    endcase
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      state_q <= fetch_pkg::APB_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Address captured on acceptance, held until completion
  always_ff @(posedge CLK) begin
    if (req_valid && req_ready) begin
      addr_q <= req_addr;
    end
  end

  // Only accepts when no transfer is open
  assign req_ready = (state_q == fetch_pkg::APB_IDLE);

  // Completion in the cycle pready ends the access phase
  assign rsp_valid = (state_q == fetch_pkg::APB_ACCESS) && pready;
  assign rsp_data  = prdata;

  // Bus drive, reads only
  assign paddr   = addr_q;
  assign psel    = (state_q != fetch_pkg::APB_IDLE);
  assign penable = (state_q == fetch_pkg::APB_ACCESS);
  assign pwrite  = 1'b0;

  // Access phase always preceded by a setup cycle at the same address
  a_setup_before_access: assert property (
    @(posedge CLK) disable iff (!nRST)
    $rose(penable) |-> $past(psel) && !$past(penable) && $stable(paddr)
  );

endmodule

/* src/btb_predictor.sv */
//********************************************************************
// Direct-mapped branch target buffer
// Combinational lookup for the fetch pc, trained by jump resolve
//********************************************************************

module btb_predictor #(
  parameter int BTB_ENTRIES = 16
) (
  input  logic             CLK,
  input  logic             nRST,
  // Lookup
  input  fetch_pkg::word_t lookup_pc,
  output logic             pred_taken,
  output fetch_pkg::word_t pred_target,
  // Training from resolve
  input  logic             train_valid,
  input  fetch_pkg::word_t train_pc,
  input  fetch_pkg::word_t train_target,
  input  logic             train_set
);

  // Index sits above the byte offset, tag takes the rest
  localparam int IDX_W = $clog2(BTB_ENTRIES);
  localparam int TAG_W = 30 - IDX_W;

  typedef logic [IDX_W-1:0] idx_t;
  typedef logic [TAG_W-1:0] tag_t;

  logic [BTB_ENTRIES-1:0] valid_q;
  tag_t                   tag_q    [BTB_ENTRIES];
  fetch_pkg::word_t       target_q [BTB_ENTRIES];

  idx_t lk_idx, tr_idx;
  tag_t lk_tag, tr_tag;

  assign lk_idx = lookup_pc[IDX_W+1:2];
  assign lk_tag = lookup_pc[31:IDX_W+2];
  assign tr_idx = train_pc[IDX_W+1:2];
  assign tr_tag = train_pc[31:IDX_W+2];

  // Hit needs a live entry with matching tag
  assign pred_taken  = valid_q[lk_idx] && (tag_q[lk_idx] == lk_tag);
  assign pred_target = target_q[lk_idx];

  // Valid bits, set or cleared by training
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      valid_q <= '0;
    end else if (train_valid) begin
      valid_q[tr_idx] <= train_set;
    end
  end

  // Tag and target only written on a set
  always_ff @(posedge CLK) begin
    if (train_valid && train_set) begin
      tag_q[tr_idx]    <= tr_tag;
      target_q[tr_idx] <= train_target;
    end
  end

endmodule

/* src/fetch_stage.sv */
//********************************************************************
// Fetch stage
// Program counter, next-pc choice, stale read squash and the
// fetch register feeding jump resolve
//********************************************************************

module fetch_stage #(
  parameter fetch_pkg::word_t RESET_PC = 32'h0000_0000
) (
  input  logic             CLK,
  input  logic             nRST,
  // Memory requester
  output logic             req_valid,
  output fetch_pkg::word_t req_addr,
  input  logic             req_ready,
  input  logic             rsp_valid,
  input  fetch_pkg::word_t rsp_data,
  // Predictor
  output fetch_pkg::word_t lookup_pc,
  input  logic             pred_taken,
  input  fetch_pkg::word_t pred_target,
  // Fetch register
  output logic             fr_valid,
  output fetch_pkg::word_t fr_pc,
  output fetch_pkg::word_t fr_pc4,
  output fetch_pkg::word_t fr_instr,
  output logic             fr_pred_taken,
  output fetch_pkg::word_t fr_pred_target,
  output logic             fr_fault,
  input  logic             fr_ready,
  // From resolve
  input  logic             redirect_valid,
  input  fetch_pkg::word_t redirect_pc,
  input  logic             halt
);

  fetch_pkg::word_t pc_q, pc4, next_pc;
  logic pending_q, stale_q;
  logic fr_room, pc_misaligned, fill, fault_issue, fr_load;

  assign pc4       = pc_q + 32'd4;
  assign lookup_pc = pc_q;

  // Predicted target on a hit, else sequential
  assign next_pc = pred_taken ? pred_target : pc4;

  // Register free now or draining this cycle
  assign fr_room       = !fr_valid || fr_ready;
  assign pc_misaligned = (pc_q[1:0] != 2'b00);

  // One read in flight, never on a redirect cycle
  assign req_valid = !pending_q && !halt && fr_room && !pc_misaligned && !redirect_valid;
  assign req_addr  = pc_q;

  // Data from a read issued before a redirect is dropped
  assign fill = rsp_valid && !stale_q;

  // Misaligned pc skips memory and makes a fault token
  assign fault_issue = !pending_q && !halt && fr_room && pc_misaligned && !redirect_valid;
  assign fr_load     = (fill || fault_issue) && !redirect_valid;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      pc_q      <= RESET_PC;
      pending_q <= 1'b0;
      stale_q   <= 1'b0;
    end else begin
      if (redirect_valid) begin
        pc_q <= redirect_pc;
      end else if (fill || fault_issue) begin
        pc_q <= next_pc;
      end
      // Outstanding read tracking
      if (rsp_valid) begin
        pending_q <= 1'b0;
      end else if (req_valid && req_ready) begin
        pending_q <= 1'b1;
      end
      // Squash flag lives until that read completes
      if (rsp_valid) begin
        stale_q <= 1'b0;
      end else if (redirect_valid && pending_q) begin
        stale_q <= 1'b1;
      end
    end
  end

  // Fetch register occupancy, flushed by redirect
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      fr_valid <= 1'b0;
    end else if (redirect_valid) begin
      fr_valid <= 1'b0;
    end else if (fill || fault_issue) begin
      fr_valid <= 1'b1;
    end else if (fr_ready) begin
      fr_valid <= 1'b0;
    end
  end

  // Token payload
  always_ff @(posedge CLK) begin
    if (fr_load) begin
      fr_pc          <= pc_q;
      fr_pc4         <= pc4;
      fr_instr       <= fill ? rsp_data : '0;
      fr_pred_taken  <= pred_taken;
      fr_pred_target <= pred_target;
      fr_fault       <= !fill;
    end
  end

  // A completing read never lands on a token resolve has not taken
  a_fill_has_room: assert property (
    @(posedge CLK) disable iff (!nRST)
    (fill && !redirect_valid) |-> (!fr_valid || fr_ready)
  );

endmodule

/* src/jump_resolve_stage.sv */
//********************************************************************
// Jump resolve stage
// Decodes JAL, checks the prediction, redirects and trains fetch,
// stops on a misaligned target and drives the retire handshake
//********************************************************************

module jump_resolve_stage (
  input  logic             CLK,
  input  logic             nRST,
  // Fetch register
  input  logic             fr_valid,
  input  fetch_pkg::word_t fr_pc,
  input  fetch_pkg::word_t fr_pc4,
  input  fetch_pkg::word_t fr_instr,
  input  logic             fr_pred_taken,
  input  fetch_pkg::word_t fr_pred_target,
  input  logic             fr_fault,
  output logic             fr_ready,
  // Redirect to fetch
  output logic             redirect_valid,
  output fetch_pkg::word_t redirect_pc,
  // Predictor training
  output logic             train_valid,
  output fetch_pkg::word_t train_pc,
  output fetch_pkg::word_t train_target,
  output logic             train_set,
  output logic             halt,
  // Retire port
  output logic             retire_valid,
  output fetch_pkg::word_t retire_pc,
  output fetch_pkg::word_t retire_instr,
  output logic             retire_fault,
  input  logic             retire_ready
);

  fetch_pkg::opcode_t opcode;
  fetch_pkg::word_t   j_imm, jal_target, actual_npc, pred_npc;
  logic is_jal, fault, enter;

  // Slot empty or leaving this cycle
  assign fr_ready = !retire_valid || retire_ready;
  assign enter    = fr_valid && fr_ready;

  // J-type immediate, bit 0 implied zero
  assign opcode = fr_instr[6:0];
  assign is_jal = (opcode == fetch_pkg::OPC_JAL);
  assign j_imm  = {{11{fr_instr[31]}}, fr_instr[31], fr_instr[19:12],
                   fr_instr[20], fr_instr[30:21], 1'b0};

  assign jal_target = fr_pc + j_imm;
  assign actual_npc = is_jal ? jal_target : fr_pc4;
  assign pred_npc   = fr_pred_taken ? fr_pred_target : fr_pc4;

  // Misaligned JAL target, or fetch already flagged the token
  assign fault = fr_fault || (is_jal && (jal_target[1:0] != 2'b00));

  // Fault also redirects so the younger token is flushed
  assign redirect_valid = enter && ((pred_npc != actual_npc) || fault);
  assign redirect_pc    = actual_npc;

  // Set on every JAL, drop a stale hit on anything else
  assign train_valid  = enter && !fr_fault && (is_jal || fr_pred_taken);
  assign train_set    = is_jal;
  assign train_pc     = fr_pc;
  assign train_target = jal_target;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      retire_valid <= 1'b0;
      halt         <= 1'b0;
    end else begin
      if (enter) begin
        retire_valid <= 1'b1;
      end else if (retire_ready) begin
        retire_valid <= 1'b0;
      end
      // Sticky until reset
      if (enter && fault) begin
        halt <= 1'b1;
      end
    end
  end

  // Retire payload
  always_ff @(posedge CLK) begin
    if (enter) begin
      retire_pc    <= fr_pc;
      retire_instr <= fr_instr;
      retire_fault <= fault;
    end
  end

  // Held token must not change under back-pressure
  a_retire_hold: assert property (
    @(posedge CLK) disable iff (!nRST)
    (retire_valid && !retire_ready) |=>
      retire_valid && $stable(retire_pc) && $stable(retire_instr) && $stable(retire_fault)
  );

endmodule

/* src/fetch_top.sv */
//********************************************************************
// Instruction fetch front end
// APB requester, target buffer, fetch and jump resolve stages
//********************************************************************

module fetch_top #(
  parameter fetch_pkg::word_t RESET_PC    = 32'h0000_0000,
  parameter int               BTB_ENTRIES = 16
) (
  input  logic             CLK,
  input  logic             nRST,
  // Instruction memory APB
  output fetch_pkg::word_t paddr,
  output logic             psel,
  output logic             penable,
  output logic             pwrite,
  input  fetch_pkg::word_t prdata,
  input  logic             pready,
  // Retire port
  output logic             retire_valid,
  output fetch_pkg::word_t retire_pc,
  output fetch_pkg::word_t retire_instr,
  output logic             retire_fault,
  input  logic             retire_ready
);

  // Fetch to requester
  logic             req_valid, req_ready, rsp_valid;
  fetch_pkg::word_t req_addr, rsp_data;

  // Predictor lookup and training
  fetch_pkg::word_t lookup_pc, pred_target, train_pc, train_target;
  logic             pred_taken, train_valid, train_set;

  // Fetch register
  logic             fr_valid, fr_pred_taken, fr_fault, fr_ready;
  fetch_pkg::word_t fr_pc, fr_pc4, fr_instr, fr_pred_target;

  // Control back to fetch
  logic             redirect_valid, halt;
  fetch_pkg::word_t redirect_pc;

  imem_apb_master apb_i (
    .CLK       (CLK),
    .nRST      (nRST),
    .req_valid (req_valid),
    .req_addr  (req_addr),
    .req_ready (req_ready),
    .rsp_valid (rsp_valid),
    .rsp_data  (rsp_data),
    .paddr     (paddr),
    .psel      (psel),
    .penable   (penable),
    .pwrite    (pwrite),
    .prdata    (prdata),
    .pready    (pready)
  );

  btb_predictor #(
    .BTB_ENTRIES (BTB_ENTRIES)
  ) btb_i (
    .CLK          (CLK),
    .nRST         (nRST),
    .lookup_pc    (lookup_pc),
    .pred_taken   (pred_taken),
    .pred_target  (pred_target),
    .train_valid  (train_valid),
    .train_pc     (train_pc),
    .train_target (train_target),
    .train_set    (train_set)
  );

  fetch_stage #(
    .RESET_PC (RESET_PC)
  ) fetch_i (
    .CLK            (CLK),
    .nRST           (nRST),
    .req_valid      (req_valid),
    .req_addr       (req_addr),
    .req_ready      (req_ready),
    .rsp_valid      (rsp_valid),
    .rsp_data       (rsp_data),
    .lookup_pc      (lookup_pc),
    .pred_taken     (pred_taken),
    .pred_target    (pred_target),
    .fr_valid       (fr_valid),
    .fr_pc          (fr_pc),
    .fr_pc4         (fr_pc4),
    .fr_instr       (fr_instr),
    .fr_pred_taken  (fr_pred_taken),
    .fr_pred_target (fr_pred_target),
    .fr_fault       (fr_fault),
    .fr_ready       (fr_ready),
    .redirect_valid (redirect_valid),
    .redirect_pc    (redirect_pc),
    .halt           (halt)
  );

  jump_resolve_stage resolve_i (
    .CLK            (CLK),
    .nRST           (nRST),
    .fr_valid       (fr_valid),
    .fr_pc          (fr_pc),
    .fr_pc4         (fr_pc4),
    .fr_instr       (fr_instr),
    .fr_pred_taken  (fr_pred_taken),
    .fr_pred_target (fr_pred_target),
    .fr_fault       (fr_fault),
    .fr_ready       (fr_ready),
    .redirect_valid (redirect_valid),
    .redirect_pc    (redirect_pc),
    .train_valid    (train_valid),
    .train_pc       (train_pc),
    .train_target   (train_target),
    .train_set      (train_set),
    .halt           (halt),
    .retire_valid   (retire_valid),
    .retire_pc      (retire_pc),
    .retire_instr   (retire_instr),
    .retire_fault   (retire_fault),
    .retire_ready   (retire_ready)
  );

endmodule

/* verif/tb_imem_apb_slave.sv */
//********************************************************************
// APB instruction memory model
// Serves the program image with 0 to 3 random wait states
//********************************************************************

module tb_imem_apb_slave #(
  parameter fetch_pkg::word_t BASE = 32'h0000_0000,
  parameter logic [31:0]      SEED = 32'h4659_4627
) (
  input  logic             CLK,
  input  logic             nRST,
  input  fetch_pkg::word_t paddr,
  input  logic             psel,
  input  logic             penable,
  output fetch_pkg::word_t prdata,
  output logic             pready,
  // Program image, 16 words from BASE
  input  fetch_pkg::word_t image [16]
);
  timeunit 1ns;
  timeprecision 100ps;

  logic [31:0] rng;
  // Wait states still owed in the current access phase
  logic [1:0]  wait_left;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] s;
    s = x ^ (x << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  // Image word, or a non-JAL filler built from the whole address
  function automatic fetch_pkg::word_t read_word(input fetch_pkg::word_t addr);
    fetch_pkg::word_t off;
    fetch_pkg::word_t data;
    off = addr - BASE;
    if (off < 32'd64) begin
      data = image[off[5:2]];
    end else begin
      data = {addr[31:7] ^ addr[24:0], 7'b0010011};
    end
    return data;
  endfunction

  // Responses change on the falling edge, sampled on the next rising one
  initial begin
    rng       = SEED;
    wait_left = 2'd0;
    pready    = 1'b0;
    prdata    = '0;
    forever begin
      @(negedge CLK);
      if (!nRST) begin
        pready    = 1'b0;
        wait_left = 2'd0;
      end else if (psel && !penable) begin
        // Setup cycle, draw this transfer's wait count
        rng       = xorshift32(rng);
        wait_left = rng[1:0];
        pready    = 1'b0;
      end else if (psel && penable && (wait_left == 2'd0)) begin
        pready = 1'b1;
        prdata = read_word(paddr);
      end else if (psel && penable) begin
        wait_left = wait_left - 2'd1;
        pready    = 1'b0;
      end else begin
        pready = 1'b0;
      end
    end
  end

endmodule

/* verif/tb_fetch_top.sv */
//********************************************************************
// Fetch front end testbench
// Builds a looping JAL program, follows it with a reference pc
// model and checks APB, retire order, hold and fault stop
//********************************************************************

module tb_fetch_top;
  timeunit 1ns;
  timeprecision 100ps;

  localparam fetch_pkg::word_t RESET_PC    = 32'h0000_0200;
  localparam int               BTB_ENTRIES = 16;
  localparam int               IMAGE_WORDS = 16;
  localparam logic [31:0]      SEED        = 32'h4659_4627;
  localparam int RESET_CYCLES = 3;
  // 14 passes of 13 tokens plus 9, then 9 tokens up to the fault
  localparam int P1_RETIRES   = 191;
  localparam int P2_RETIRES   = 9;
  localparam int QUIET_CYCLES = 40;
  localparam int TIMEOUT_CYCLES =
    40 * (P1_RETIRES + P2_RETIRES) + 2 * RESET_CYCLES + QUIET_CYCLES;
  // Loop-back JAL, and the JAL bent to a misaligned target later
  localparam int LOOP_WORD  = 15;
  localparam int FAULT_WORD = 9;
  localparam fetch_pkg::word_t LOOP_PC = RESET_PC + 4 * LOOP_WORD;

  logic             CLK, nRST;
  fetch_pkg::word_t paddr, prdata;
  logic             psel, penable, pwrite, pready;
  logic             retire_valid, retire_fault, retire_ready;
  fetch_pkg::word_t retire_pc, retire_instr;

  // Program image and the step each word takes
  fetch_pkg::word_t image   [IMAGE_WORDS];
  logic             is_jal  [IMAGE_WORDS];
  fetch_pkg::word_t jal_off [IMAGE_WORDS];

  // Reference model and checker state
  fetch_pkg::word_t exp_pc, last_jal_target, prev_paddr, prev_rpc, prev_rinstr;
  logic fault_seen, loop_done, last_jal_setup, was_reset;
  logic jal_rsp_seen, jal_setup_due;
  logic prev_psel, prev_penable, prev_open, prev_hold, prev_rfault;
  int   retired, cycles;
  int   retire_errors, apb_errors, hold_errors, predict_errors;
  logic [31:0] ready_rng;

  fetch_top #(
    .RESET_PC    (RESET_PC),
    .BTB_ENTRIES (BTB_ENTRIES)
  ) dut_i (
    .CLK          (CLK),
    .nRST         (nRST),
    .paddr        (paddr),
    .psel         (psel),
    .penable      (penable),
    .pwrite       (pwrite),
    .prdata       (prdata),
    .pready       (pready),
    .retire_valid (retire_valid),
    .retire_pc    (retire_pc),
    .retire_instr (retire_instr),
    .retire_fault (retire_fault),
    .retire_ready (retire_ready)
  );

  tb_imem_apb_slave #(
    .BASE (RESET_PC),
    .SEED (SEED)
  ) mem_i (
    .CLK     (CLK),
    .nRST    (nRST),
    .paddr   (paddr),
    .psel    (psel),
    .penable (penable),
    .prdata  (prdata),
    .pready  (pready),
    .image   (image)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] s;
    s = x ^ (x << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  // J-type layout imm[20|10:1|11|19:12]
  function automatic fetch_pkg::word_t encode_jal(input logic [20:0] imm,
                                                  input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, fetch_pkg::OPC_JAL};
  endfunction

  function automatic logic [3:0] word_index(input fetch_pkg::word_t addr);
    fetch_pkg::word_t off;
    off = addr - RESET_PC;
    return off[5:2];
  endfunction

  function automatic logic in_image(input fetch_pkg::word_t addr);
    fetch_pkg::word_t off;
    off = addr - RESET_PC;
    return off < 4 * IMAGE_WORDS;
  endfunction

  // JAL goes to pc plus offset, everything else falls through
  function automatic fetch_pkg::word_t ref_next_pc(input fetch_pkg::word_t pc);
    fetch_pkg::word_t next;
    if (is_jal[word_index(pc)]) begin
      next = pc + jal_off[word_index(pc)];
    end else begin
      next = pc + 32'd4;
    end
    return next;
  endfunction

  function automatic logic ref_fault(input fetch_pkg::word_t pc);
    fetch_pkg::word_t target;
    target = pc + jal_off[word_index(pc)];
    return is_jal[word_index(pc)] && (target[1:0] != 2'b00);
  endfunction

  task automatic place_jal(input int w, input int off);
    image[w]   = encode_jal(off[20:0], 5'd1);
    is_jal[w]  = 1'b1;
    jal_off[w] = off;
  endtask

  // Mix of ADDI, LUI and ADD, then three JALs
  task automatic build_image();
    for (int i = 0; i < IMAGE_WORDS; i++) begin
      is_jal[i]  = 1'b0;
      jal_off[i] = 32'd4;
      case (i % 3)
        0:       image[i] = {i[11:0], 5'd0, 3'b000, i[4:0], 7'b0010011};
        1:       image[i] = {i[19:0] ^ 20'h5a5a5, i[4:0], 7'b0110111};
        default: image[i] = {7'd0, i[4:0], 5'd2, 3'b000, i[4:0], 7'b0110011};
      endcase
    end
    place_jal(3, 8);
    place_jal(FAULT_WORD, 12);
    place_jal(LOOP_WORD, -4 * LOOP_WORD);
  endtask

  task automatic check_apb();
    assert (!pwrite) else begin
      apb_errors++;
      $display("Mismatch pwrite: got %h, expected 0", pwrite);
    end
    if (was_reset) begin
      assert (!psel && !penable) else begin
        apb_errors++;
        $display("APB transfer open in the first cycle after reset");
      end
    end
    if (psel) begin
      assert (paddr[1:0] == 2'b00) else begin
        apb_errors++;
        $display("Mismatch paddr[1:0]: got %h, expected 0", paddr[1:0]);
      end
    end
    // Access phase only straight after a setup at the same address
    if (penable && !prev_penable) begin
      assert (prev_psel && psel && (paddr == prev_paddr)) else begin
        apb_errors++;
        $display("Access phase at %h without a setup cycle before it", paddr);
      end
    end
    if (prev_open) begin
      assert (psel && (paddr == prev_paddr)) else begin
        apb_errors++;
        $display("Mismatch paddr: got %h, expected %h", paddr, prev_paddr);
      end
    end
  endtask

  // Stalled token stays put
  task automatic check_hold();
    if (prev_hold) begin
      assert (retire_valid) else begin
        hold_errors++;
        $display("retire_valid dropped while retire_ready was low");
      end
      assert (retire_pc == prev_rpc) else begin
        hold_errors++;
        $display("Mismatch retire_pc: got %h, expected %h", retire_pc, prev_rpc);
      end
      assert (retire_instr == prev_rinstr) else begin
        hold_errors++;
        $display("Mismatch retire_instr: got %h, expected %h", retire_instr, prev_rinstr);
      end
      assert (retire_fault == prev_rfault) else begin
        hold_errors++;
        $display("Mismatch retire_fault: got %h, expected %h", retire_fault, prev_rfault);
      end
    end
  endtask

  // Once trained, a JAL fetch is followed by a fetch at its target
  // Without a prediction that setup waits a cycle for the redirect
  task automatic check_setup();
    if (loop_done && jal_setup_due) begin
      assert (psel && !penable) else begin
        predict_errors++;
        $display("No APB setup at the predicted target right after a JAL read");
      end
    end
    if (psel && !penable) begin
      assert (!fault_seen) else begin
        apb_errors++;
        $display("APB setup at %h after the faulting token retired", paddr);
      end
      if (loop_done && last_jal_setup) begin
        assert (paddr == last_jal_target) else begin
          predict_errors++;
          $display("Mismatch paddr: got %h, expected %h", paddr, last_jal_target);
        end
      end
      last_jal_setup  = in_image(paddr) && is_jal[word_index(paddr)];
      last_jal_target = paddr + jal_off[word_index(paddr)];
    end
    // Resolve can take the JAL in the cycle after its read completes
    jal_setup_due = jal_rsp_seen && (!retire_valid || retire_ready);
    jal_rsp_seen  = psel && penable && pready && in_image(paddr)
                    && is_jal[word_index(paddr)];
  endtask

  task automatic check_retire();
    if (fault_seen) begin
      assert (!retire_valid) else begin
        retire_errors++;
        $display("Token at %h offered after the faulting token", retire_pc);
      end
    end
    if (retire_valid && retire_ready) begin
      assert (retire_pc == exp_pc) else begin
        retire_errors++;
        $display("Mismatch retire_pc: got %h, expected %h", retire_pc, exp_pc);
      end
      assert (retire_instr == image[word_index(exp_pc)]) else begin
        retire_errors++;
        $display("Mismatch retire_instr: got %h, expected %h", retire_instr,
                 image[word_index(exp_pc)]);
      end
      assert (retire_fault == ref_fault(exp_pc)) else begin
        retire_errors++;
        $display("Mismatch retire_fault: got %h, expected %h", retire_fault,
                 ref_fault(exp_pc));
      end
      if (retire_fault) begin
        fault_seen = 1'b1;
      end
      if (exp_pc == LOOP_PC) begin
        loop_done = 1'b1;
      end
      exp_pc = ref_next_pc(exp_pc);
      retired++;
    end
  endtask

  // Single checker process, samples on the rising edge
  always @(posedge CLK) begin
    if (!nRST) begin
      assert (!psel && !penable && !retire_valid) else begin
        apb_errors++;
        $display("APB or retire port active during reset");
      end
      exp_pc         = RESET_PC;
      fault_seen     = 1'b0;
      loop_done      = 1'b0;
      last_jal_setup = 1'b0;
      jal_rsp_seen   = 1'b0;
      jal_setup_due  = 1'b0;
      was_reset      = 1'b1;
      prev_psel      = 1'b0;
      prev_penable   = 1'b0;
      prev_open      = 1'b0;
      prev_hold      = 1'b0;
    end else begin
      check_apb();
      check_hold();
      check_setup();
      check_retire();
      // History for next cycle
      prev_psel    = psel;
      prev_penable = penable;
      prev_paddr   = paddr;
      prev_open    = psel && !(penable && pready);
      prev_hold    = retire_valid && !retire_ready;
      prev_rpc     = retire_pc;
      prev_rinstr  = retire_instr;
      prev_rfault  = retire_fault;
      was_reset    = 1'b0;
    end
  end

  initial begin
    CLK = 1'b0;
    forever #2 CLK = ~CLK;
  end

  // Random back-pressure, about a quarter of cycles stalled
  initial begin
    ready_rng    = SEED;
    retire_ready = 1'b0;
    forever begin
      @(negedge CLK);
      ready_rng    = xorshift32(ready_rng);
      retire_ready = (ready_rng[1:0] != 2'b00);
    end
  end

  initial begin
    cycles = 0;
    while (cycles < TIMEOUT_CYCLES) begin
      @(posedge CLK);
      cycles++;
    end
    $display("Timeout after %0d cycles with %0d tokens retired", cycles, retired);
    $display("test failed");
    $finish;
  end

  initial begin
    retired        = 0;
    retire_errors  = 0;
    apb_errors     = 0;
    hold_errors    = 0;
    predict_errors = 0;
    nRST           = 1'b0;
    build_image();
    repeat (RESET_CYCLES) @(negedge CLK);
    nRST = 1'b1;
    while (retired < P1_RETIRES) @(negedge CLK);
    // Fresh reset, then one JAL lands two bytes off
    nRST = 1'b0;
    place_jal(FAULT_WORD, 2);
    repeat (RESET_CYCLES) @(negedge CLK);
    nRST = 1'b1;
    while (!fault_seen) @(negedge CLK);
    // Quiet window, nothing may move after the fault
    repeat (QUIET_CYCLES) @(negedge CLK);
    $display("Errors: retire %0d, apb %0d, hold %0d, predict %0d (%0d retired)",
             retire_errors, apb_errors, hold_errors, predict_errors, retired);
    if ((retire_errors + apb_errors + hold_errors + predict_errors) == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

/* sources.f */
src/fetch_pkg.sv
src/imem_apb_master.sv
src/btb_predictor.sv
src/fetch_stage.sv
src/jump_resolve_stage.sv
src/fetch_top.sv
verif/tb_imem_apb_slave.sv
verif/tb_fetch_top.sv

/* Makefile */
# Verilator build and run for the fetch front end testbench
# Override any variable on the command line, e.g. make run LOG=run2.log

VERILATOR ?= verilator
TOP       ?= tb_fetch_top
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
TIMESCALE ?= 1ns/100ps
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= test passed

SRCS := $(shell grep -v '^+' $(FILELIST))
SIM  := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --timescale $(TIMESCALE) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -f $(FILELIST)

# Pass only if the pass line shows up in the log
run: compile
	./$(SIM) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
